/* logic/ddr_rd_defines.svh */
`ifndef DDR_RD_DEFINES_SVH
`define DDR_RD_DEFINES_SVH

// 32-bit words packed in one 256-bit ddr beat
`define DDR_RD_WORDS_PER_BEAT 8

// ddr native port takes a 4-bit length
`define DDR_RD_MAX_BURST 16

// read buffer size in beats, 256 words
`define DDR_RD_FIFO_BEATS 32

// refill point in words
// at or below this level one full 16-beat burst still fits
`define DDR_RD_REFILL_WORDS 128

`endif

/* logic/host_rd_pkg.sv */
package host_rd_pkg;

    // upstream burst bus fields
    typedef logic [3:0]  host_id_t;    // transaction id
    typedef logic [27:0] host_addr_t;  // word address
    typedef logic [7:0]  host_len_t;   // words minus one
    typedef logic [31:0] host_data_t;  // one data word

    // read bridge control
    typedef enum logic [2:0] {
        IDLE       = 3'b000,  // waiting for a request
        WAIT       = 3'b001,  // draining words, deciding on a refill
        TRANS_ADDR = 3'b010,  // ddr request out
        TRANS_DATA = 3'b011,  // ddr burst coming back
        FLUSH      = 3'b100   // drop trailing words
    } rd_state_e;

endpackage

/* logic/ddr_native_pkg.sv */
package ddr_native_pkg;

    // ddr3 controller native port
    typedef logic [27:0]  ddr_addr_t;  // word address, low 3 bits zero
    typedef logic [3:0]   ddr_len_t;   // beats minus one
    typedef logic [255:0] ddr_data_t;  // one beat

    // read buffer fill level in 32-bit words, 0 to 256
    typedef logic [8:0]   fifo_words_t;

endpackage

/* logic/rstn_sync.sv */
`timescale 1ns/1ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic ddr_rstn_sync
);

    logic rstn_meta;  // first stage, may go metastable on release

    // assert at once, release two edges later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_meta     <= 1'b0;
            ddr_rstn_sync <= 1'b0;
        end else begin
            rstn_meta     <= 1'b1;
            ddr_rstn_sync <= rstn_meta;
        end
    end

endmodule

/* logic/rd_width_fifo.sv */
`timescale 1ns/1ps
`include "ddr_rd_defines.svh"

module rd_width_fifo (
    input  logic                      clk,
    input  logic                      ddr_rstn_sync,
    input  logic                      flush,
    input  logic                      wr_en,
    input  ddr_native_pkg::ddr_data_t wr_data,
    input  logic                      rd_en,
    output host_rd_pkg::host_data_t   rd_word,
    output logic                      empty,
    output logic                      almost_empty
);

    localparam int BEAT_AW = $clog2(`DDR_RD_FIFO_BEATS);
    localparam int SEL_W   = $clog2(`DDR_RD_WORDS_PER_BEAT);
    localparam int WORD_W  = $bits(host_rd_pkg::host_data_t);

    ddr_native_pkg::ddr_data_t   mem [`DDR_RD_FIFO_BEATS];
    logic [BEAT_AW-1:0]          wr_ptr;
    logic [BEAT_AW-1:0]          rd_beat;  // beat being unpacked
    logic [SEL_W-1:0]            rd_sel;   // word within that beat
    ddr_native_pkg::fifo_words_t word_cnt;
    ddr_native_pkg::fifo_words_t cnt_nxt;
    logic                        rd_ok;

    assign rd_ok = rd_en && !empty;  // a read of an empty buffer is ignored

    // beat storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + BEAT_AW'(1);  // wraps at the buffer end
        end
    end

    // read side steps through words 31:0 first, then moves to the next beat
    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            rd_beat <= '0;
            rd_sel  <= '0;
        end else if (flush) begin
            rd_beat <= '0;
            rd_sel  <= '0;
        end else if (rd_ok) begin
            rd_sel <= rd_sel + SEL_W'(1);
            if (&rd_sel) begin  // last word of the beat
                rd_beat <= rd_beat + BEAT_AW'(1);
            end
        end
    end

    // output register, valid one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rd_word <= mem[rd_beat][rd_sel*WORD_W +: WORD_W];
        end
    end

    // fill level in words
    always_comb begin
        cnt_nxt = word_cnt;
        if (wr_en) begin
            cnt_nxt = cnt_nxt + ddr_native_pkg::fifo_words_t'(`DDR_RD_WORDS_PER_BEAT);
        end
        if (rd_ok) begin
            cnt_nxt = cnt_nxt - ddr_native_pkg::fifo_words_t'(1);
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            word_cnt <= '0;
        end else if (flush) begin
            word_cnt <= '0;  // drops whatever is left
        end else begin
            word_cnt <= cnt_nxt;
        end
    end

    assign empty        = (word_cnt == '0);
    assign almost_empty = (word_cnt <= ddr_native_pkg::fifo_words_t'(`DDR_RD_REFILL_WORDS));

endmodule

/* logic/ddr3_read.sv */
`timescale 1ns/1ps
`include "ddr_rd_defines.svh"

module ddr3_read (
    input  logic                      clk,
    input  logic                      ddr_rstn_sync,
    // upstream address
    input  host_rd_pkg::host_id_t     rd_addr_id,
    input  host_rd_pkg::host_addr_t   rd_addr,
    input  host_rd_pkg::host_len_t    rd_addr_len,
    input  logic                      rd_addr_valid,
    output logic                      rd_addr_ready,
    // upstream data
    output host_rd_pkg::host_id_t     rd_id,
    output host_rd_pkg::host_data_t   rd_data,
    output logic                      rd_last,
    output logic                      rd_valid,
    input  logic                      rd_ready,
    // ddr request
    output ddr_native_pkg::ddr_addr_t ddr_addr,
    output ddr_native_pkg::ddr_len_t  ddr_len,
    output host_rd_pkg::host_id_t     ddr_id,
    output logic                      ddr_addr_valid,
    input  logic                      ddr_addr_ready,
    // ddr return, the beat itself goes straight into the fifo
    input  logic                      ddr_data_last,
    input  logic                      ddr_data_valid,
    // read buffer
    output logic                      fifo_flush,
    output logic                      fifo_rd_en,
    input  host_rd_pkg::host_data_t   fifo_word,
    input  logic                      fifo_empty,
    input  logic                      fifo_almost_empty
);

    localparam int BEAT_SHIFT = $clog2(`DDR_RD_WORDS_PER_BEAT);

    host_rd_pkg::rd_state_e    state;
    host_rd_pkg::rd_state_e    state_nxt;
    host_rd_pkg::host_id_t     id_q;
    ddr_native_pkg::ddr_addr_t addr_q;       // next burst address
    host_rd_pkg::host_len_t    beats_rem;    // beats still to request, minus one
    host_rd_pkg::host_len_t    word_cnt;     // words left after the one on rd_data
    logic [BEAT_SHIFT-1:0]     discard_cnt;  // leading words to drop
    logic                      addr_done;    // final burst already requested
    logic                      first_need;   // output register holds nothing useful
    host_rd_pkg::host_addr_t   addr_end;
    host_rd_pkg::host_len_t    burst_beats;
    logic                      active;
    logic                      last_burst;
    logic                      addr_hs;
    logic                      ddr_hs;
    logic                      data_hs;
    logic                      discard_need;

    assign addr_hs = rd_addr_valid && rd_addr_ready;
    assign ddr_hs  = ddr_addr_valid && ddr_addr_ready;
    assign data_hs = rd_valid && rd_ready;

    assign active = (state == host_rd_pkg::WAIT) ||
                    (state == host_rd_pkg::TRANS_ADDR) ||
                    (state == host_rd_pkg::TRANS_DATA);

    // last word of the request
    assign addr_end = rd_addr + host_rd_pkg::host_addr_t'(rd_addr_len);

    // burst splitting
    assign last_burst  = (beats_rem < host_rd_pkg::host_len_t'(`DDR_RD_MAX_BURST));
    assign ddr_len     = last_burst ? ddr_native_pkg::ddr_len_t'(beats_rem)
                                    : ddr_native_pkg::ddr_len_t'(`DDR_RD_MAX_BURST - 1);
    assign burst_beats = host_rd_pkg::host_len_t'(ddr_len) + host_rd_pkg::host_len_t'(1);

    always_comb begin
        state_nxt = state;
        case (state)
            host_rd_pkg::IDLE: begin
                if (addr_hs) begin
                    state_nxt = host_rd_pkg::WAIT;
                end
            end
            host_rd_pkg::WAIT: begin
                if (data_hs && rd_last) begin
                    state_nxt = host_rd_pkg::FLUSH;
                end else if (fifo_almost_empty && !addr_done) begin
                    state_nxt = host_rd_pkg::TRANS_ADDR;  // room for a full burst
                end
            end
            host_rd_pkg::TRANS_ADDR: begin
                if (ddr_hs) begin
                    state_nxt = host_rd_pkg::TRANS_DATA;
                end
            end
            host_rd_pkg::TRANS_DATA: begin
                if (ddr_data_valid && ddr_data_last) begin
                    state_nxt = host_rd_pkg::WAIT;
                end
            end
            host_rd_pkg::FLUSH: begin
                state_nxt = host_rd_pkg::IDLE;
            end
            default: begin
                state_nxt = host_rd_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state <= host_rd_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request fields
    always_ff @(posedge clk) begin
        if (addr_hs) begin
            id_q   <= rd_addr_id;
            addr_q <= ddr_native_pkg::ddr_addr_t'(
                          rd_addr & ~host_rd_pkg::host_addr_t'(`DDR_RD_WORDS_PER_BEAT - 1));
        end else if (ddr_hs && !last_burst) begin
            addr_q <= addr_q + (ddr_native_pkg::ddr_addr_t'(burst_beats) << BEAT_SHIFT);
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            beats_rem <= '0;
            addr_done <= 1'b0;
        end else if (addr_hs) begin
            // end beat minus start beat
            beats_rem <= host_rd_pkg::host_len_t'((addr_end >> BEAT_SHIFT) -
                                                  (rd_addr >> BEAT_SHIFT));
            addr_done <= 1'b0;
        end else if (ddr_hs) begin
            if (last_burst) begin
                addr_done <= 1'b1;
            end else begin
                beats_rem <= beats_rem - burst_beats;
            end
        end
    end

    assign discard_need = active && (discard_cnt != '0);

    // word bookkeeping on the upstream side
    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            discard_cnt <= '0;
            word_cnt    <= '0;
        end else if (addr_hs) begin
            discard_cnt <= rd_addr[BEAT_SHIFT-1:0];
            word_cnt    <= rd_addr_len;
        end else begin
            if (fifo_rd_en && !first_need && discard_need) begin
                discard_cnt <= discard_cnt - BEAT_SHIFT'(1);  // overwrite an unwanted word
            end
            if (data_hs && (word_cnt != '0)) begin
                word_cnt <= word_cnt - host_rd_pkg::host_len_t'(1);
            end
        end
    end

    // the output register needs a priming read after a flush
    // and again once it is consumed while the fifo is empty
    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            first_need <= 1'b1;
        end else if (fifo_flush) begin
            first_need <= 1'b1;
        end else if (fifo_rd_en) begin
            first_need <= 1'b0;
        end else if (data_hs && fifo_empty) begin
            first_need <= 1'b1;
        end
    end

    assign fifo_rd_en = active && !fifo_empty && (discard_need || first_need || data_hs);
    assign fifo_flush = (state == host_rd_pkg::FLUSH);

    assign rd_addr_ready = (state == host_rd_pkg::IDLE);
    assign rd_valid      = active && !first_need && !discard_need;
    assign rd_last       = rd_valid && (word_cnt == '0);
    assign rd_data       = fifo_word;
    assign rd_id         = id_q;  // ddr returns in order

    assign ddr_addr       = addr_q;
    assign ddr_id         = id_q;
    assign ddr_addr_valid = (state == host_rd_pkg::TRANS_ADDR);

endmodule

/* logic/ddr_rd_top.sv */
`timescale 1ns/1ps

module ddr_rd_top (
    input  logic                      clk,
    input  logic                      rstn,
    // upstream address
    input  host_rd_pkg::host_id_t     rd_addr_id,
    input  host_rd_pkg::host_addr_t   rd_addr,
    input  host_rd_pkg::host_len_t    rd_addr_len,
    input  logic                      rd_addr_valid,
    output logic                      rd_addr_ready,
    // upstream data
    output host_rd_pkg::host_id_t     rd_id,
    output host_rd_pkg::host_data_t   rd_data,
    output logic                      rd_last,
    output logic                      rd_valid,
    input  logic                      rd_ready,
    // ddr native port
    output ddr_native_pkg::ddr_addr_t ddr_addr,
    output ddr_native_pkg::ddr_len_t  ddr_len,
    output host_rd_pkg::host_id_t     ddr_id,
    output logic                      ddr_addr_valid,
    input  logic                      ddr_addr_ready,
    input  ddr_native_pkg::ddr_data_t ddr_data,
    input  logic                      ddr_data_last,
    input  logic                      ddr_data_valid
);

    logic                    ddr_rstn_sync;
    logic                    fifo_flush;
    logic                    fifo_rd_en;
    logic                    fifo_empty;
    logic                    fifo_almost_empty;
    host_rd_pkg::host_data_t fifo_word;

    rstn_sync i_rstn_sync (
        .clk           (clk),
        .rstn          (rstn),
        .ddr_rstn_sync (ddr_rstn_sync)
    );

    ddr3_read i_ddr3_read (
        .clk               (clk),
        .ddr_rstn_sync     (ddr_rstn_sync),
        .rd_addr_id        (rd_addr_id),
        .rd_addr           (rd_addr),
        .rd_addr_len       (rd_addr_len),
        .rd_addr_valid     (rd_addr_valid),
        .rd_addr_ready     (rd_addr_ready),
        .rd_id             (rd_id),
        .rd_data           (rd_data),
        .rd_last           (rd_last),
        .rd_valid          (rd_valid),
        .rd_ready          (rd_ready),
        .ddr_addr          (ddr_addr),
        .ddr_len           (ddr_len),
        .ddr_id            (ddr_id),
        .ddr_addr_valid    (ddr_addr_valid),
        .ddr_addr_ready    (ddr_addr_ready),
        .ddr_data_last     (ddr_data_last),
        .ddr_data_valid    (ddr_data_valid),
        .fifo_flush        (fifo_flush),
        .fifo_rd_en        (fifo_rd_en),
        .fifo_word         (fifo_word),
        .fifo_empty        (fifo_empty),
        .fifo_almost_empty (fifo_almost_empty)
    );

    // every returned beat is written, the ddr side cannot be stalled
    rd_width_fifo i_rd_width_fifo (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .flush         (fifo_flush),
        .wr_en         (ddr_data_valid),
        .wr_data       (ddr_data),
        .rd_en         (fifo_rd_en),
        .rd_word       (fifo_word),
        .empty         (fifo_empty),
        .almost_empty  (fifo_almost_empty)
    );

endmodule

/* verif/tb_ddr_rd_top.sv */
`timescale 1ns/1ps
`include "ddr_rd_defines.svh"

module tb_ddr_rd_top;

    logic                      clk;
    logic                      rstn;
    host_rd_pkg::host_id_t     rd_addr_id, rd_id, ddr_id;
    host_rd_pkg::host_addr_t   rd_addr;
    host_rd_pkg::host_len_t    rd_addr_len;
    host_rd_pkg::host_data_t   rd_data;
    logic                      rd_addr_valid, rd_addr_ready, rd_last, rd_valid, rd_ready;
    ddr_native_pkg::ddr_addr_t ddr_addr;
    ddr_native_pkg::ddr_len_t  ddr_len;
    ddr_native_pkg::ddr_data_t ddr_data;
    logic                      ddr_addr_valid, ddr_addr_ready, ddr_data_last, ddr_data_valid;

    logic [15:0]               resp_lfsr;      // ddr model delays
    logic [15:0]               host_lfsr;      // rd_ready toggling
    int                        errors;
    int                        tests;
    ddr_native_pkg::ddr_addr_t req_addr_q[$];  // requests seen by the ddr model
    ddr_native_pkg::ddr_len_t  req_len_q[$];
    host_rd_pkg::host_id_t     req_id_q[$];

    ddr_rd_top i_ddr_rd_top (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(st[0]);
            st  = lfsr_step(st);  // one step per bit taken
        end
    endtask

    // contents of the modeled ddr memory
    function automatic host_rd_pkg::host_data_t pattern(host_rd_pkg::host_addr_t a);
        return host_rd_pkg::host_data_t'(a) ^ 32'h5A5A0000;
    endfunction

    task automatic report_fail(string tn, logic [31:0] e, logic [31:0] a);
        errors++;
        $display("Fail %s: expected %0h, actual %0h", tn, e, a);
    endtask

    task automatic compare_word(string tn, host_rd_pkg::host_data_t e, a);
        if (a !== e) report_fail(tn, e, a);
    endtask

    task automatic compare_id(string tn, host_rd_pkg::host_id_t e, a);
        if (a !== e) report_fail(tn, 32'(e), 32'(a));
    endtask

    task automatic compare_len(string tn, ddr_native_pkg::ddr_len_t e, a);
        if (a !== e) report_fail(tn, 32'(e), 32'(a));
    endtask

    task automatic compare_addr(string tn, ddr_native_pkg::ddr_addr_t e, a);
        if (a !== e) report_fail(tn, 32'(e), 32'(a));
    endtask

    task automatic compare_last(string tn, logic e, a);
        if (a !== e) report_fail(tn, 32'(e), 32'(a));
    endtask

    task automatic compare_count(string tn, int e, a);
        if (a != e) report_fail(tn, e, a);
    endtask

    task automatic test_done(string tn, int err_start);
        tests++;
        if (errors == err_start) $display("%s: ok", tn);
        else $display("%s: %0d errors", tn, errors - err_start);
    endtask

    // ddr controller model returns a burst after a random delay
    initial begin : ddr_model
        int                        delay;
        ddr_native_pkg::ddr_addr_t a;
        ddr_native_pkg::ddr_len_t  n;
        resp_lfsr      = 16'd7840;
        ddr_data       = '0;
        ddr_data_valid = 1'b0;
        ddr_data_last  = 1'b0;
        forever begin
            @(negedge clk);
            ddr_data_valid = 1'b0;
            ddr_data_last  = 1'b0;
            if (ddr_addr_valid && ddr_addr_ready) begin  // taken on the next rising edge
                a = ddr_addr;
                n = ddr_len;
                req_addr_q.push_back(a);
                req_len_q.push_back(n);
                req_id_q.push_back(ddr_id);
                draw_bits(resp_lfsr, 3, delay);
                repeat (delay + 1) @(negedge clk);
                for (int b = 0; b <= int'(n); b++) begin
                    if (b > 0) @(negedge clk);
                    for (int w = 0; w < `DDR_RD_WORDS_PER_BEAT; w++) begin
                        ddr_data[w*32 +: 32] = pattern(a + host_rd_pkg::host_addr_t'(
                                                   b * `DDR_RD_WORDS_PER_BEAT + w));
                    end
                    ddr_data_valid = 1'b1;
                    ddr_data_last  = (b == int'(n));
                end
            end
        end
    end

    // one upstream request followed by every word up to rd_last
    task automatic read_and_check(string tn, host_rd_pkg::host_id_t id,
                                  host_rd_pkg::host_addr_t addr, host_rd_pkg::host_len_t len,
                                  bit throttle);
        int got;
        int idle;
        int r;
        int n_beats;
        bit seen_last;
        got       = 0;
        idle      = 0;
        seen_last = 1'b0;
        n_beats   = (int'(addr) + int'(len)) / `DDR_RD_WORDS_PER_BEAT
                    - int'(addr) / `DDR_RD_WORDS_PER_BEAT + 1;
        req_id_q.delete();
        while (!rd_addr_ready && idle < 100) begin
            @(negedge clk);
            idle++;
        end
        if (!rd_addr_ready) begin
            errors++;
            $display("%s: timed out waiting for rd_addr_ready", tn);
        end
        rd_addr_id    = id;
        rd_addr       = addr;
        rd_addr_len   = len;
        rd_addr_valid = 1'b1;
        @(negedge clk);
        rd_addr_valid = 1'b0;
        idle          = 0;
        while (!seen_last && got <= int'(len) && idle < 400) begin
            r = 1;
            if (throttle) draw_bits(host_lfsr, 1, r);
            rd_ready = (r != 0);
            if (rd_addr_ready) begin
                errors++;
                $display("%s: rd_addr_ready went high before rd_last", tn);
                break;
            end
            if (rd_valid && rd_ready) begin  // word moves on the next rising edge
                compare_word(tn, pattern(addr + host_rd_pkg::host_addr_t'(got)), rd_data);
                compare_id(tn, id, rd_id);
                compare_last(tn, got == int'(len), rd_last);
                seen_last = rd_last;
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(negedge clk);
        end
        rd_ready = 1'b0;
        if (idle >= 400) begin
            errors++;
            $display("%s: timed out waiting for read data", tn);
        end
        compare_count(tn, int'(len) + 1, got);
        // every burst of the request carries its id
        compare_count({tn, " ddr requests"},
                      (n_beats + `DDR_RD_MAX_BURST - 1) / `DDR_RD_MAX_BURST,
                      req_id_q.size());
        foreach (req_id_q[i]) begin
            compare_id({tn, " ddr_id"}, id, req_id_q[i]);
        end
    endtask

    task automatic reset_and_single();
        int e0;
        e0 = errors;
        compare_last("reset rd_valid", 1'b0, rd_valid);
        compare_last("reset rd_last", 1'b0, rd_last);
        compare_last("reset ddr_addr_valid", 1'b0, ddr_addr_valid);
        compare_last("reset rd_addr_ready", 1'b1, rd_addr_ready);
        read_and_check("single_word", 4'h3, 28'h0000100, 8'd0, 1'b0);
        test_done("reset_and_single", e0);
    endtask

    task automatic unaligned_read();
        int e0;
        e0 = errors;
        read_and_check("unaligned", 4'h6, 28'h0000235, 8'd9, 1'b0);
        test_done("unaligned", e0);
    endtask

    task automatic long_read();
        int                        e0;
        int                        beats;
        int                        total;
        host_rd_pkg::host_addr_t   start;
        ddr_native_pkg::ddr_addr_t exp_addr;
        e0       = errors;
        start    = 28'h0001003;
        beats    = (int'(start) + 255) / 8 - int'(start) / 8 + 1;  // end beat minus start beat plus one
        total    = 0;
        exp_addr = start & ~28'h7;
        req_addr_q.delete();
        req_len_q.delete();
        read_and_check("long_read", 4'hA, start, 8'd255, 1'b0);
        foreach (req_addr_q[i]) begin
            compare_addr("long_read addr", exp_addr, req_addr_q[i]);
            compare_len("long_read len", ddr_native_pkg::ddr_len_t'(
                            (beats - total > `DDR_RD_MAX_BURST) ? `DDR_RD_MAX_BURST - 1
                                                                : beats - total - 1),
                        req_len_q[i]);
            exp_addr = exp_addr + ddr_native_pkg::ddr_addr_t'(8 * (int'(req_len_q[i]) + 1));
            total    = total + int'(req_len_q[i]) + 1;
        end
        compare_count("long_read beats", beats, total);
        test_done("long_read", e0);
    endtask

    task automatic throttled_read();
        int e0;
        e0 = errors;
        read_and_check("throttled", 4'h1, 28'h0002011, 8'd99, 1'b1);
        test_done("throttled", e0);
    endtask

    // trailing words of each request sit in the fifo until the flush
    task automatic back_to_back();
        int e0;
        e0 = errors;
        read_and_check("b2b_first", 4'h5, 28'h0003002, 8'd20, 1'b0);
        read_and_check("b2b_second", 4'h9, 28'h0003107, 8'd3, 1'b1);
        read_and_check("b2b_third", 4'hC, 28'h0003200, 8'd130, 1'b0);
        test_done("back_to_back", e0);
    endtask

    initial begin
        errors         = 0;
        tests          = 0;
        host_lfsr      = 16'd7840;
        rstn           = 1'b0;
        rd_addr_id     = '0;
        rd_addr        = '0;
        rd_addr_len    = '0;
        rd_addr_valid  = 1'b0;
        rd_ready       = 1'b0;
        ddr_addr_ready = 1'b1;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);  // synchronizer release
        reset_and_single();
        unaligned_read();
        long_read();
        throttled_read();
        back_to_back();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
logic/host_rd_pkg.sv
logic/ddr_native_pkg.sv
logic/rstn_sync.sv
logic/rd_width_fifo.sv
logic/ddr3_read.sv
logic/ddr_rd_top.sv
verif/tb_ddr_rd_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ddr_rd_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
